// File: compile.f
+incdir+dv
logic/isa_pkg.sv
logic/core_cfg_pkg.sv
logic/instr_decode.sv
logic/reg_file.sv
logic/instr_execute.sv
logic/memory_access.sv
logic/write_back.sv
logic/core_top.sv
dv/core_tb.sv

// File: Makefile
VERILATOR   ?= verilator
LINT_FLAGS  = --lint-only --timing --assert
SIM_FLAGS   = --binary --timing --assert
TOP         = core_tb
RTL_TOP     = core_top
FILELIST    = compile.f
BUILD_DIR   = obj_dir
LOG         = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Regression passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: dv/core_tb_table.svh
localparam int TABLE_LEN = 31;

// per row the entry, instruction word, write-back flag, register and data
task automatic fill_table();
    // seed operands
    set_entry( 0, 32'h20010005, 1'b1, 5'd1,  32'h00000005);   // addi r1, r0, 5
    set_entry( 1, 32'h2002fffd, 1'b1, 5'd2,  32'hfffffffd);   // addi r2, r0, -3
    // alu ops on the seeds
    set_entry( 2, 32'h00221820, 1'b1, 5'd3,  32'h00000002);   // add r3, r1, r2
    set_entry( 3, 32'h00222022, 1'b1, 5'd4,  32'h00000008);   // sub r4, r1, r2
    set_entry( 4, 32'h00222824, 1'b1, 5'd5,  32'h00000005);   // and r5, r1, r2
    set_entry( 5, 32'h00223025, 1'b1, 5'd6,  32'hfffffffd);   // or r6, r1, r2
    set_entry( 6, 32'h0041382a, 1'b1, 5'd7,  32'h00000001);   // slt r7, r2, r1
    set_entry( 7, 32'h0022402a, 1'b1, 5'd8,  32'h00000000);   // slt r8, r1, r2
    set_entry( 8, 32'h2009fff9, 1'b1, 5'd9,  32'hfffffff9);   // addi r9, r0, -7
    set_entry( 9, 32'h0122502a, 1'b1, 5'd10, 32'h00000001);   // slt r10, r9, r2
    // chain on r11
    set_entry(10, 32'h200b0001, 1'b1, 5'd11, 32'h00000001);   // addi r11, r0, 1
    set_entry(11, 32'h016b5820, 1'b1, 5'd11, 32'h00000002);   // add r11, r11, r11
    set_entry(12, 32'h016b5820, 1'b1, 5'd11, 32'h00000004);   // add r11, r11, r11
    set_entry(13, 32'h216b0003, 1'b1, 5'd11, 32'h00000007);   // addi r11, r11, 3
    set_entry(14, 32'h01616022, 1'b1, 5'd12, 32'h00000002);   // sub r12, r11, r1
    // word round trip at 0x44
    set_entry(15, 32'h200d1234, 1'b1, 5'd13, 32'h00001234);   // addi r13, r0, 0x1234
    set_entry(16, 32'h200e0040, 1'b1, 5'd14, 32'h00000040);   // addi r14, r0, 0x40
    set_entry(17, 32'hadcd0004, 1'b0, 5'd0,  32'h00000000);   // sw r13, 4(r14)
    set_entry(18, 32'h8dcf0004, 1'b1, 5'd15, 32'h00001234);   // lw r15, 4(r14)
    // narrow stores of 0x80a5 extended to a whole word
    set_entry(19, 32'h201080a5, 1'b1, 5'd16, 32'hffff80a5);   // addi r16, r0, 0x80a5
    set_entry(20, 32'ha1d00008, 1'b0, 5'd0,  32'h00000000);   // sb r16, 8(r14)
    set_entry(21, 32'h81d10008, 1'b1, 5'd17, 32'hffffffa5);   // lb r17, 8(r14)
    set_entry(22, 32'h91d20008, 1'b1, 5'd18, 32'h000000a5);   // lbu r18, 8(r14)
    set_entry(23, 32'ha5d0000c, 1'b0, 5'd0,  32'h00000000);   // sh r16, 12(r14)
    set_entry(24, 32'h85d3000c, 1'b1, 5'd19, 32'hffff80a5);   // lh r19, 12(r14)
    set_entry(25, 32'h95d4000c, 1'b1, 5'd20, 32'h000080a5);   // lhu r20, 12(r14)
    set_entry(26, 32'h8dd50008, 1'b1, 5'd21, 32'hffffffa5);   // lw r21, 8(r14)
    // r0 target is dropped and r0 source reads zero
    set_entry(27, 32'h20000055, 1'b0, 5'd0,  32'h00000000);   // addi r0, r0, 0x55
    set_entry(28, 32'h000db020, 1'b1, 5'd22, 32'h00001234);   // add r22, r0, r13
    set_entry(29, 32'h02cfb820, 1'b1, 5'd23, 32'h00002468);   // add r23, r22, r15
    set_entry(30, 32'h0272c024, 1'b1, 5'd24, 32'h000000a5);   // and r24, r19, r18
endtask

// File: dv/core_tb.sv
module core_tb;

    `include "core_tb_table.svh"

    localparam int RESET_CYCLES    = 16;
    localparam int HALT_IDX        = 12;   // halt lands while this entry is in flight
    localparam int HALT_MAX_CYCLES = 10;
    localparam int DRAIN_CYCLES    = 8;
    localparam int TIMEOUT_CYCLES  = TABLE_LEN * 20 + RESET_CYCLES + HALT_MAX_CYCLES;

    logic                              clk;
    logic                              rst_n;
    logic                              halt;
    logic                              instr_req;
    logic [core_cfg_pkg::NB_INSTR-1:0] instr;
    logic                              instr_ack;
    logic                              wb_valid;
    logic [core_cfg_pkg::NB_REG-1:0]   wb_reg;
    logic [core_cfg_pkg::NB_DATA-1:0]  wb_data;

    logic [core_cfg_pkg::NB_INSTR-1:0] tbl_instr [TABLE_LEN];
    logic                              tbl_wb    [TABLE_LEN];
    logic [core_cfg_pkg::NB_REG-1:0]   tbl_reg   [TABLE_LEN];
    logic [core_cfg_pkg::NB_DATA-1:0]  tbl_data  [TABLE_LEN];

    int          wb_order [$];   // table entries that retire a write, in program order
    int          wb_seen        = 0;
    int          mismatch_count = 0;
    int          other_count    = 0;
    int          cycle_count    = 0;
    logic        req_seen       = 1'b0;
    logic [15:0] lfsr_state     = 16'd4;

    core_top u_dut (
        .clk         (clk),
        .i_rst_n     (rst_n),
        .i_halt      (halt),
        .i_instr_req (instr_req),
        .i_instr     (instr),
        .o_instr_ack (instr_ack),
        .o_wb_valid  (wb_valid),
        .o_wb_reg    (wb_reg),
        .o_wb_data   (wb_data)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic set_entry(input int idx, input logic [31:0] word, input logic wb,
                             input logic [4:0] rd, input logic [31:0] data);
        tbl_instr[idx] = word;
        tbl_wb[idx]    = wb;
        tbl_reg[idx]   = rd;
        tbl_data[idx]  = data;
    endtask

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        logic fb;
        fb = state[15] ^ state[13] ^ state[12] ^ state[10];
        return {state[14:0], fb};
    endfunction

    task automatic draw_bits(input int n, output int val);
        val = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            val        = (val << 1) | int'(lfsr_state[0]);
        end
    endtask

    // one full four-phase cycle with random gaps between phases
    task automatic send_instr(input int idx);
        int gap;
        int halt_len;
        @(posedge clk);
        instr_req <= 1'b1;
        instr     <= tbl_instr[idx];
        req_seen   = 1'b1;
        @(negedge clk);
        while (!instr_ack) begin
            @(negedge clk);
        end
        if (idx == HALT_IDX) begin
            draw_bits(3, halt_len);
            halt_len = halt_len + 3;
            @(posedge clk);
            halt <= 1'b1;   // freezes the entry just captured
            repeat (halt_len) @(posedge clk);
            halt <= 1'b0;
        end
        draw_bits(2, gap);
        repeat (gap) @(posedge clk);
        @(posedge clk);
        instr_req <= 1'b0;
        @(negedge clk);
        while (instr_ack) begin
            @(negedge clk);
        end
        draw_bits(2, gap);
        repeat (gap) @(posedge clk);
    endtask

    task automatic check_writeback(input int idx);
        assert (wb_reg == tbl_reg[idx]) else begin
            mismatch_count++;
            $display("mismatch o_wb_reg entry %0d: got 0x%h, expected 0x%h",
                     idx, wb_reg, tbl_reg[idx]);
        end
        assert (wb_data == tbl_data[idx]) else begin
            mismatch_count++;
            $display("mismatch o_wb_data entry %0d: got 0x%h, expected 0x%h",
                     idx, wb_data, tbl_data[idx]);
        end
    endtask

    task automatic print_summary();
        $display("%0d mismatches, %0d other errors, %0d of %0d write-backs seen",
                 mismatch_count, other_count, wb_seen, wb_order.size());
    endtask

    // outputs are sampled on the falling edge, away from the driving edge
    always @(negedge clk) begin
        if (!req_seen) begin
            assert (instr_ack == 1'b0 && wb_valid == 1'b0) else begin
                other_count++;
                $display("ack or write-back active before the first request at %0t", $time);
            end
        end
        if (wb_valid) begin
            assert (!halt) else begin
                other_count++;
                $display("write-back pulse appeared while halt was high at %0t", $time);
            end
            assert (wb_seen < wb_order.size()) else begin
                other_count++;
                $display("write-back to r%0d arrived after all expected ones", wb_reg);
            end
            if (wb_seen < wb_order.size()) begin
                check_writeback(wb_order[wb_seen]);
            end
            wb_seen++;
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES) begin
            other_count++;
            $display("timeout after %0d cycles, the core stopped making progress", cycle_count);
            print_summary();
            $display("Regression failed");
            $finish;
        end
    end

    initial begin
        rst_n     = 1'b0;
        halt      = 1'b0;
        instr_req = 1'b0;
        instr     = '0;
        fill_table();
        for (int i = 0; i < TABLE_LEN; i++) begin
            if (tbl_wb[i]) begin
                wb_order.push_back(i);
            end
        end
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        for (int i = 0; i < TABLE_LEN; i++) begin
            send_instr(i);
        end
        while (wb_seen < wb_order.size()) begin
            @(negedge clk);
        end
        repeat (DRAIN_CYCLES) @(negedge clk);   // catch stray pulses
        print_summary();
        if (mismatch_count == 0 && other_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: logic/core_top.sv
module core_top (
    input  logic                              clk,
    input  logic                              i_rst_n,
    input  logic                              i_halt,
    input  logic                              i_instr_req,
    input  logic [core_cfg_pkg::NB_INSTR-1:0] i_instr,
    output logic                              o_instr_ack,
    output logic                              o_wb_valid,
    output logic [core_cfg_pkg::NB_REG-1:0]   o_wb_reg,
    output logic [core_cfg_pkg::NB_DATA-1:0]  o_wb_data
);

    logic [core_cfg_pkg::NB_REG-1:0]  rs_idx, rt_idx;
    logic [core_cfg_pkg::NB_DATA-1:0] rs_val, rt_val;

    // decode to execute
    logic                             d_valid, d_use_imm, d_reg_write;
    logic                             d_mem_read, d_mem_write, d_sign;
    logic [2:0]                       d_alu_op;
    logic [isa_pkg::NB_IMM-1:0]       d_imm;
    logic [core_cfg_pkg::NB_DATA-1:0] d_rs_val, d_rt_val;
    logic [core_cfg_pkg::NB_REG-1:0]  d_dst;
    logic [1:0]                       d_width;

    // execute to memory
    logic                             e_valid, e_reg_write, e_mem_read, e_mem_write, e_sign;
    logic [core_cfg_pkg::NB_DATA-1:0] e_result, e_store_data;
    logic [core_cfg_pkg::NB_REG-1:0]  e_dst;
    logic [1:0]                       e_width;

    // memory to write-back
    logic                             m_valid, m_reg_write, m_mem2reg, m_sign;
    logic [core_cfg_pkg::NB_DATA-1:0] m_mem_word, m_alu_result;
    logic [core_cfg_pkg::NB_REG-1:0]  m_dst;
    logic [1:0]                       m_width;

    logic                             wb_we;
    logic [core_cfg_pkg::NB_REG-1:0]  wb_reg;
    logic [core_cfg_pkg::NB_DATA-1:0] wb_data;

    instr_decode u_decode (
        .clk         (clk),         .i_rst_n     (i_rst_n),
        .i_halt      (i_halt),      .i_instr_req (i_instr_req),
        .i_instr     (i_instr),     .i_rs_val    (rs_val),
        .i_rt_val    (rt_val),      .i_wb_we     (wb_we),
        .i_wb_reg    (wb_reg),      .o_instr_ack (o_instr_ack),
        .o_rs_idx    (rs_idx),      .o_rt_idx    (rt_idx),
        .o_valid     (d_valid),     .o_alu_op    (d_alu_op),
        .o_use_imm   (d_use_imm),   .o_imm       (d_imm),
        .o_rs_val    (d_rs_val),    .o_rt_val    (d_rt_val),
        .o_dst       (d_dst),       .o_reg_write (d_reg_write),
        .o_mem_read  (d_mem_read),  .o_mem_write (d_mem_write),
        .o_width     (d_width),     .o_sign      (d_sign)
    );

    reg_file u_reg_file (
        .clk       (clk),      .i_rst_n   (i_rst_n),
        .i_rs_idx  (rs_idx),   .i_rt_idx  (rt_idx),
        .i_we      (wb_we),    .i_wr_idx  (wb_reg),
        .i_wr_data (wb_data),  .o_rs_val  (rs_val),
        .o_rt_val  (rt_val)
    );

    instr_execute u_execute (
        .clk          (clk),           .i_rst_n      (i_rst_n),
        .i_halt       (i_halt),        .i_valid      (d_valid),
        .i_alu_op     (d_alu_op),      .i_use_imm    (d_use_imm),
        .i_imm        (d_imm),         .i_rs_val     (d_rs_val),
        .i_rt_val     (d_rt_val),      .i_dst        (d_dst),
        .i_reg_write  (d_reg_write),   .i_mem_read   (d_mem_read),
        .i_mem_write  (d_mem_write),   .i_width      (d_width),
        .i_sign       (d_sign),        .o_valid      (e_valid),
        .o_result     (e_result),      .o_store_data (e_store_data),
        .o_dst        (e_dst),         .o_reg_write  (e_reg_write),
        .o_mem_read   (e_mem_read),    .o_mem_write  (e_mem_write),
        .o_width      (e_width),       .o_sign       (e_sign)
    );

    memory_access u_memory (
        .clk          (clk),           .i_rst_n      (i_rst_n),
        .i_halt       (i_halt),        .i_valid      (e_valid),
        .i_result     (e_result),      .i_store_data (e_store_data),
        .i_dst        (e_dst),         .i_reg_write  (e_reg_write),
        .i_mem_read   (e_mem_read),    .i_mem_write  (e_mem_write),
        .i_width      (e_width),       .i_sign       (e_sign),
        .o_valid      (m_valid),       .o_mem_word   (m_mem_word),
        .o_alu_result (m_alu_result),  .o_dst        (m_dst),
        .o_reg_write  (m_reg_write),   .o_mem2reg    (m_mem2reg),
        .o_width      (m_width),       .o_sign       (m_sign)
    );

    write_back u_write_back (
        .clk          (clk),           .i_rst_n      (i_rst_n),
        .i_halt       (i_halt),        .i_valid      (m_valid),
        .i_mem_word   (m_mem_word),    .i_alu_result (m_alu_result),
        .i_dst        (m_dst),         .i_reg_write  (m_reg_write),
        .i_mem2reg    (m_mem2reg),     .i_width      (m_width),
        .i_sign       (m_sign),        .o_wb_we      (wb_we),
        .o_wb_reg     (wb_reg),        .o_wb_data    (wb_data)
    );

    // the register-file write doubles as the observation port
    assign o_wb_valid = wb_we;
    assign o_wb_reg   = wb_reg;
    assign o_wb_data  = wb_data;

endmodule

// File: logic/write_back.sv
module write_back (
    input  logic                             clk,
    input  logic                             i_rst_n,
    input  logic                             i_halt,
    input  logic                             i_valid,
    input  logic [core_cfg_pkg::NB_DATA-1:0] i_mem_word,
    input  logic [core_cfg_pkg::NB_DATA-1:0] i_alu_result,
    input  logic [core_cfg_pkg::NB_REG-1:0]  i_dst,
    input  logic                             i_reg_write,
    input  logic                             i_mem2reg,
    input  logic [1:0]                       i_width,
    input  logic                             i_sign,
    output logic                             o_wb_we,
    output logic [core_cfg_pkg::NB_REG-1:0]  o_wb_reg,
    output logic [core_cfg_pkg::NB_DATA-1:0] o_wb_data
);

    logic [core_cfg_pkg::NB_DATA-1:0] load_val;
    logic [core_cfg_pkg::NB_DATA-1:0] result;
    logic                             we_q;

    always_comb begin
        case (i_width)
            isa_pkg::WIDTH_BYTE: load_val = i_sign ?
                {{(core_cfg_pkg::NB_DATA-8){i_mem_word[7]}}, i_mem_word[7:0]} :
                {{(core_cfg_pkg::NB_DATA-8){1'b0}}, i_mem_word[7:0]};
            isa_pkg::WIDTH_HALF: load_val = i_sign ?
                {{(core_cfg_pkg::NB_DATA-16){i_mem_word[15]}}, i_mem_word[15:0]} :
                {{(core_cfg_pkg::NB_DATA-16){1'b0}}, i_mem_word[15:0]};
            default:             load_val = i_mem_word;
        endcase
    end

    assign result = i_mem2reg ? load_val : i_alu_result;

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            we_q <= 1'b0;
        end else if (!i_halt) begin
            we_q <= i_valid & i_reg_write & (i_dst != '0);   // r0 targets dropped
        end
    end

    always_ff @(posedge clk) begin
        if (!i_halt) begin
            o_wb_reg  <= i_dst;
            o_wb_data <= result;
        end
    end

    // a write caught by halt is held and leaves once halt drops
    assign o_wb_we = we_q & ~i_halt;

endmodule

// File: logic/memory_access.sv
module memory_access (
    input  logic                             clk,
    input  logic                             i_rst_n,
    input  logic                             i_halt,
    input  logic                             i_valid,
    input  logic [core_cfg_pkg::NB_DATA-1:0] i_result,
    input  logic [core_cfg_pkg::NB_DATA-1:0] i_store_data,
    input  logic [core_cfg_pkg::NB_REG-1:0]  i_dst,
    input  logic                             i_reg_write,
    input  logic                             i_mem_read,
    input  logic                             i_mem_write,
    input  logic [1:0]                       i_width,
    input  logic                             i_sign,
    output logic                             o_valid,
    output logic [core_cfg_pkg::NB_DATA-1:0] o_mem_word,
    output logic [core_cfg_pkg::NB_DATA-1:0] o_alu_result,
    output logic [core_cfg_pkg::NB_REG-1:0]  o_dst,
    output logic                             o_reg_write,
    output logic                             o_mem2reg,
    output logic [1:0]                       o_width,
    output logic                             o_sign
);

    logic [core_cfg_pkg::NB_DATA-1:0] mem [core_cfg_pkg::MEM_DEPTH];
    logic [core_cfg_pkg::NB_DATA-1:0] store_word;
    logic [core_cfg_pkg::NB_DATA-1:0] rd_word;
    logic [core_cfg_pkg::NB_ADDR-1:0] addr;
    logic                             mem_we;

    // narrow stores fill the whole word
    always_comb begin
        case (i_width)
            isa_pkg::WIDTH_BYTE: store_word = i_sign ?
                {{(core_cfg_pkg::NB_DATA-8){i_store_data[7]}}, i_store_data[7:0]} :
                {{(core_cfg_pkg::NB_DATA-8){1'b0}}, i_store_data[7:0]};
            isa_pkg::WIDTH_HALF: store_word = i_sign ?
                {{(core_cfg_pkg::NB_DATA-16){i_store_data[15]}}, i_store_data[15:0]} :
                {{(core_cfg_pkg::NB_DATA-16){1'b0}}, i_store_data[15:0]};
            isa_pkg::WIDTH_WORD: store_word = i_store_data;
            default:             store_word = '0;
        endcase
    end

    assign addr    = i_result[core_cfg_pkg::NB_ADDR-1:0];
    assign mem_we  = i_valid & i_mem_write & ~i_halt;
    assign rd_word = mem[addr];   // asynchronous read

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < core_cfg_pkg::MEM_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (mem_we) begin
            mem[addr] <= store_word;
        end
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_valid     <= 1'b0;
            o_reg_write <= 1'b0;
        end else if (!i_halt) begin
            o_valid     <= i_valid;
            o_reg_write <= i_reg_write;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_halt) begin
            o_mem_word   <= rd_word;
            o_alu_result <= i_result;
            o_dst        <= i_dst;
            o_mem2reg    <= i_mem_read;   // loads take the memory word
            o_width      <= i_width;
            o_sign       <= i_sign;
        end
    end

    // decode only emits byte, half and word stores
    store_width_legal: assert property (@(posedge clk) disable iff (!i_rst_n)
        (i_valid && i_mem_write) |-> i_width != 2'b11);

endmodule

// File: logic/instr_execute.sv
module instr_execute (
    input  logic                             clk,
    input  logic                             i_rst_n,
    input  logic                             i_halt,
    input  logic                             i_valid,
    input  logic [2:0]                       i_alu_op,
    input  logic                             i_use_imm,
    input  logic [isa_pkg::NB_IMM-1:0]       i_imm,
    input  logic [core_cfg_pkg::NB_DATA-1:0] i_rs_val,
    input  logic [core_cfg_pkg::NB_DATA-1:0] i_rt_val,
    input  logic [core_cfg_pkg::NB_REG-1:0]  i_dst,
    input  logic                             i_reg_write,
    input  logic                             i_mem_read,
    input  logic                             i_mem_write,
    input  logic [1:0]                       i_width,
    input  logic                             i_sign,
    output logic                             o_valid,
    output logic [core_cfg_pkg::NB_DATA-1:0] o_result,
    output logic [core_cfg_pkg::NB_DATA-1:0] o_store_data,
    output logic [core_cfg_pkg::NB_REG-1:0]  o_dst,
    output logic                             o_reg_write,
    output logic                             o_mem_read,
    output logic                             o_mem_write,
    output logic [1:0]                       o_width,
    output logic                             o_sign
);

    logic [core_cfg_pkg::NB_DATA-1:0] op_b;
    logic [core_cfg_pkg::NB_DATA-1:0] alu_out;

    assign op_b = i_use_imm ?
        {{(core_cfg_pkg::NB_DATA-isa_pkg::NB_IMM){i_imm[isa_pkg::NB_IMM-1]}}, i_imm} :
        i_rt_val;

    always_comb begin
        case (i_alu_op)
            isa_pkg::ALU_ADD: alu_out = i_rs_val + op_b;
            isa_pkg::ALU_SUB: alu_out = i_rs_val - op_b;
            isa_pkg::ALU_AND: alu_out = i_rs_val & op_b;
            isa_pkg::ALU_OR:  alu_out = i_rs_val | op_b;
            isa_pkg::ALU_SLT: alu_out = {{(core_cfg_pkg::NB_DATA-1){1'b0}},
                                         $signed(i_rs_val) < $signed(op_b)};
            default:          alu_out = '0;
        endcase
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_valid     <= 1'b0;
            o_reg_write <= 1'b0;
            o_mem_write <= 1'b0;
        end else if (!i_halt) begin
            o_valid     <= i_valid;
            o_reg_write <= i_reg_write;
            o_mem_write <= i_mem_write;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_halt) begin
            o_result     <= alu_out;   // also the memory address
            o_store_data <= i_rt_val;
            o_dst        <= i_dst;
            o_mem_read   <= i_mem_read;
            o_width      <= i_width;
            o_sign       <= i_sign;
        end
    end

endmodule

// File: logic/reg_file.sv
module reg_file (
    input  logic                             clk,
    input  logic                             i_rst_n,
    input  logic [core_cfg_pkg::NB_REG-1:0]  i_rs_idx,
    input  logic [core_cfg_pkg::NB_REG-1:0]  i_rt_idx,
    input  logic                             i_we,
    input  logic [core_cfg_pkg::NB_REG-1:0]  i_wr_idx,
    input  logic [core_cfg_pkg::NB_DATA-1:0] i_wr_data,
    output logic [core_cfg_pkg::NB_DATA-1:0] o_rs_val,
    output logic [core_cfg_pkg::NB_DATA-1:0] o_rt_val
);

    logic [core_cfg_pkg::NB_DATA-1:0] regs [core_cfg_pkg::N_REGS];

    function automatic logic [core_cfg_pkg::NB_DATA-1:0] read_port(
        input logic [core_cfg_pkg::NB_REG-1:0] idx
    );
        if (idx == '0) begin
            return '0;
        end
        if (i_we && idx == i_wr_idx) begin
            return i_wr_data;   // write-through
        end
        return regs[idx];
    endfunction

    always_comb begin
        o_rs_val = read_port(i_rs_idx);
        o_rt_val = read_port(i_rt_idx);
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < core_cfg_pkg::N_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we && i_wr_idx != '0) begin
            regs[i_wr_idx] <= i_wr_data;
        end
    end

    // write-back filters r0 targets before they reach here
    no_r0_write: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_we |-> i_wr_idx != '0);

endmodule

// File: logic/instr_decode.sv
module instr_decode (
    input  logic                              clk,
    input  logic                              i_rst_n,
    input  logic                              i_halt,
    input  logic                              i_instr_req,
    input  logic [core_cfg_pkg::NB_INSTR-1:0] i_instr,
    input  logic [core_cfg_pkg::NB_DATA-1:0]  i_rs_val,
    input  logic [core_cfg_pkg::NB_DATA-1:0]  i_rt_val,
    input  logic                              i_wb_we,
    input  logic [core_cfg_pkg::NB_REG-1:0]   i_wb_reg,
    output logic                              o_instr_ack,
    output logic [core_cfg_pkg::NB_REG-1:0]   o_rs_idx,
    output logic [core_cfg_pkg::NB_REG-1:0]   o_rt_idx,
    output logic                              o_valid,
    output logic [2:0]                        o_alu_op,
    output logic                              o_use_imm,
    output logic [isa_pkg::NB_IMM-1:0]        o_imm,
    output logic [core_cfg_pkg::NB_DATA-1:0]  o_rs_val,
    output logic [core_cfg_pkg::NB_DATA-1:0]  o_rt_val,
    output logic [core_cfg_pkg::NB_REG-1:0]   o_dst,
    output logic                              o_reg_write,
    output logic                              o_mem_read,
    output logic                              o_mem_write,
    output logic [1:0]                        o_width,
    output logic                              o_sign
);

    logic [5:0]                      opcode;
    logic [5:0]                      funct;
    logic [core_cfg_pkg::NB_REG-1:0] rd_idx;
    logic [core_cfg_pkg::NB_REG-1:0] dst;
    logic [2:0]                      alu_op;
    logic [1:0]                      width;
    logic                            use_imm;
    logic                            reg_write;
    logic                            mem_read;
    logic                            mem_write;
    logic                            sign;
    logic                            uses_rt;
    logic [core_cfg_pkg::N_REGS-1:0] pending;   // destinations still in flight
    logic [core_cfg_pkg::N_REGS-1:0] wb_clr;
    logic [core_cfg_pkg::N_REGS-1:0] busy;
    logic                            conflict;
    logic                            capture;

    assign opcode   = i_instr[isa_pkg::OPC_MSB:isa_pkg::OPC_LSB];
    assign funct    = i_instr[isa_pkg::FN_MSB:isa_pkg::FN_LSB];
    assign o_rs_idx = i_instr[isa_pkg::RS_MSB:isa_pkg::RS_LSB];
    assign o_rt_idx = i_instr[isa_pkg::RT_MSB:isa_pkg::RT_LSB];
    assign rd_idx   = i_instr[isa_pkg::RD_MSB:isa_pkg::RD_LSB];

    always_comb begin
        alu_op    = isa_pkg::ALU_ADD;   // i-type all add rs + imm
        use_imm   = 1'b1;
        reg_write = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        width     = isa_pkg::WIDTH_WORD;
        sign      = 1'b1;
        uses_rt   = 1'b0;
        dst       = o_rt_idx;
        case (opcode)
            isa_pkg::OPC_RTYPE: begin
                use_imm   = 1'b0;
                uses_rt   = 1'b1;
                dst       = rd_idx;
                reg_write = 1'b1;
                case (funct)
                    isa_pkg::FN_ADD: alu_op = isa_pkg::ALU_ADD;
                    isa_pkg::FN_SUB: alu_op = isa_pkg::ALU_SUB;
                    isa_pkg::FN_AND: alu_op = isa_pkg::ALU_AND;
                    isa_pkg::FN_OR:  alu_op = isa_pkg::ALU_OR;
                    isa_pkg::FN_SLT: alu_op = isa_pkg::ALU_SLT;
                    default:         reg_write = 1'b0;   // unknown funct acts as nop
                endcase
            end
            isa_pkg::OPC_ADDI: reg_write = 1'b1;
            isa_pkg::OPC_LB, isa_pkg::OPC_LBU: begin
                reg_write = 1'b1;
                mem_read  = 1'b1;
                width     = isa_pkg::WIDTH_BYTE;
                sign      = (opcode == isa_pkg::OPC_LB);
            end
            isa_pkg::OPC_LH, isa_pkg::OPC_LHU: begin
                reg_write = 1'b1;
                mem_read  = 1'b1;
                width     = isa_pkg::WIDTH_HALF;
                sign      = (opcode == isa_pkg::OPC_LH);
            end
            isa_pkg::OPC_LW: begin
                reg_write = 1'b1;
                mem_read  = 1'b1;
            end
            isa_pkg::OPC_SB, isa_pkg::OPC_SH, isa_pkg::OPC_SW: begin
                mem_write = 1'b1;
                uses_rt   = 1'b1;   // store source
                width     = (opcode == isa_pkg::OPC_SB) ? isa_pkg::WIDTH_BYTE :
                            (opcode == isa_pkg::OPC_SH) ? isa_pkg::WIDTH_HALF :
                                                          isa_pkg::WIDTH_WORD;
            end
            default: ;
        endcase
    end

    // a write retiring this cycle is already visible through the register file
    always_comb begin
        wb_clr = '0;
        if (i_wb_we) begin
            wb_clr[i_wb_reg] = 1'b1;
        end
    end

    assign busy     = pending & ~wb_clr;
    // dst check keeps two writes to one register from clearing each other early
    assign conflict = busy[o_rs_idx] | (uses_rt & busy[o_rt_idx]) | (reg_write & busy[dst]);
    assign capture  = i_instr_req & ~o_instr_ack & ~i_halt & ~conflict;

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_instr_ack <= 1'b0;
            o_valid     <= 1'b0;
            o_reg_write <= 1'b0;
            o_mem_write <= 1'b0;
            pending     <= '0;
        end else begin
            pending <= busy;
            if (capture && reg_write && dst != '0) begin
                pending[dst] <= 1'b1;   // set wins over a same-cycle clear
            end
            if (!i_halt) begin
                o_valid     <= capture;
                o_reg_write <= capture & reg_write;
                o_mem_write <= capture & mem_write;
                if (capture) begin
                    o_instr_ack <= 1'b1;
                end else if (!i_instr_req) begin
                    o_instr_ack <= 1'b0;   // second half of four-phase
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            o_alu_op   <= alu_op;
            o_use_imm  <= use_imm;
            o_imm      <= i_instr[isa_pkg::IMM_MSB:isa_pkg::IMM_LSB];
            o_rs_val   <= i_rs_val;
            o_rt_val   <= i_rt_val;
            o_dst      <= dst;
            o_mem_read <= mem_read;
            o_width    <= width;
            o_sign     <= sign;
        end
    end

    // requester must hold req until it sees the ack
    ack_needs_req: assert property (@(posedge clk) disable iff (!i_rst_n)
        $rose(o_instr_ack) |-> i_instr_req);

endmodule

// File: logic/core_cfg_pkg.sv
package core_cfg_pkg;

    localparam int NB_DATA   = 32;
    localparam int NB_INSTR  = 32;
    localparam int N_REGS    = 32;
    localparam int NB_REG    = 5;     // log2 of N_REGS
    localparam int MEM_DEPTH = 256;   // data memory words
    localparam int NB_ADDR   = 8;

endpackage

// File: logic/isa_pkg.sv
package isa_pkg;

    // major opcodes
    localparam logic [5:0] OPC_RTYPE = 6'h00;
    localparam logic [5:0] OPC_ADDI  = 6'h08;
    localparam logic [5:0] OPC_LB    = 6'h20;
    localparam logic [5:0] OPC_LH    = 6'h21;
    localparam logic [5:0] OPC_LW    = 6'h23;
    localparam logic [5:0] OPC_LBU   = 6'h24;
    localparam logic [5:0] OPC_LHU   = 6'h25;
    localparam logic [5:0] OPC_SB    = 6'h28;
    localparam logic [5:0] OPC_SH    = 6'h29;
    localparam logic [5:0] OPC_SW    = 6'h2b;

    // funct field of r-type
    localparam logic [5:0] FN_ADD = 6'h20;
    localparam logic [5:0] FN_SUB = 6'h22;
    localparam logic [5:0] FN_AND = 6'h24;
    localparam logic [5:0] FN_OR  = 6'h25;
    localparam logic [5:0] FN_SLT = 6'h2a;

    localparam logic [1:0] WIDTH_BYTE = 2'b00;
    localparam logic [1:0] WIDTH_HALF = 2'b01;
    localparam logic [1:0] WIDTH_WORD = 2'b10;   // 2'b11 is unused

    localparam logic [2:0] ALU_ADD = 3'd0;
    localparam logic [2:0] ALU_SUB = 3'd1;
    localparam logic [2:0] ALU_AND = 3'd2;
    localparam logic [2:0] ALU_OR  = 3'd3;
    localparam logic [2:0] ALU_SLT = 3'd4;

    // instruction field positions
    localparam int OPC_MSB = 31;
    localparam int OPC_LSB = 26;
    localparam int RS_MSB  = 25;
    localparam int RS_LSB  = 21;
    localparam int RT_MSB  = 20;
    localparam int RT_LSB  = 16;
    localparam int RD_MSB  = 15;
    localparam int RD_LSB  = 11;
    localparam int FN_MSB  = 5;
    localparam int FN_LSB  = 0;
    localparam int IMM_MSB = 15;
    localparam int IMM_LSB = 0;
    localparam int NB_IMM  = IMM_MSB - IMM_LSB + 1;

endpackage
